/* vlog.f */
rob_cfg_pkg.sv
rob_bus_pkg.sv
rob_entry_table.sv
rob_complete_table.sv
rob_commit_if.sv
rob.sv
commit_unit.sv
rob_top.sv
rob_asserts.sv
tb_rob_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ROB testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rob_top -f vlog.f -o sim_rob_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rob_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "result: FAIL"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "result: PASS"
exit 0

/* tb_rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob_top;

    import rob_cfg_pkg::*;

    localparam int ROB_WIDTH   = 6;
    localparam int DEPTH       = 1 << ROB_WIDTH;
    localparam int NO_CDB      = -1;
    localparam int RND_CDB     = -2;
    localparam int DRAIN_LIMIT = 400;

    logic                   clk;
    logic                   rst_i;
    logic [1:0]             dispatch_issue_i;
    logic [1:0][5:0]        dispatch_idx_i;
    logic [1:0][4:0]        dispatch_areg_i;
    logic [1:0][31:0]       dispatch_pc_i;
    logic [1:0]             dispatch_w_reg_i;
    logic [1:0]             dispatch_w_mem_i;
    logic [1:0]             cdb_w_valid_i;
    logic [1:0][5:0]        cdb_idx_i;
    logic [1:0][31:0]       cdb_w_data_i;
    rob_ctrl_e [1:0]        cdb_ctrl_i;
    logic [3:0][5:0]        src_idx_i;
    logic [3:0][31:0]       src_data_o;
    logic [3:0]             src_ready_o;
    logic [1:0]             arf_we_o;
    logic [1:0][4:0]        arf_addr_o;
    logic [1:0][31:0]       arf_data_o;
    logic                   flush_o;

    rob_top #(
        .ROB_WIDTH (ROB_WIDTH)
    ) DUT (
        .clk              (clk),
        .rst_i            (rst_i),
        .dispatch_issue_i (dispatch_issue_i),
        .dispatch_idx_i   (dispatch_idx_i),
        .dispatch_areg_i  (dispatch_areg_i),
        .dispatch_pc_i    (dispatch_pc_i),
        .dispatch_w_reg_i (dispatch_w_reg_i),
        .dispatch_w_mem_i (dispatch_w_mem_i),
        .cdb_w_valid_i    (cdb_w_valid_i),
        .cdb_idx_i        (cdb_idx_i),
        .cdb_w_data_i     (cdb_w_data_i),
        .cdb_ctrl_i       (cdb_ctrl_i),
        .src_idx_i        (src_idx_i),
        .src_data_o       (src_data_o),
        .src_ready_o      (src_ready_o),
        .arf_we_o         (arf_we_o),
        .arf_addr_o       (arf_addr_o),
        .arf_data_o       (arf_data_o),
        .flush_o          (flush_o)
    );

    bind commit_unit rob_asserts u_asserts (
        .clk          (clk),
        .rst_i        (rst_i),
        .commit_req_i (req),
        .flush_i      (flush_o),
        .arf_we_i     (arf_we_o)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // golden model and stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // one in-flight instruction, oldest at the front
    typedef struct {
        logic [5:0]  idx;
        logic [4:0]  areg;
        logic        w_reg;
        bit          done;
        bit          exc;
        logic [31:0] data;
    } ent_t;

    // cdb offsets count from the oldest in-flight entry
    typedef struct {
        string      name;
        int         reps;
        int         n_disp;
        logic [1:0] w_reg;
        int         off0;
        rob_ctrl_e  ctrl0;
        int         off1;
        rob_ctrl_e  ctrl1;
        int         exp_wr;
        bit         drain;
    } row_t;

    ent_t        rob_q [$];
    row_t        rows [$];
    logic [5:0]  m_tail;
    bit          flush_pend;
    bit          ready_m [DEPTH];
    logic [31:0] data_m [DEPTH];
    logic [31:0] lfsr_q;
    int          n_checks;
    int          guard;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        n_checks++;
        assert (act_v === exp_v) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", what, exp_v, act_v);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic ensure(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // empty ROB, flip bits equal, data cleared
    task automatic clear_model();
        rob_q.delete();
        m_tail     = '0;
        flush_pend = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            ready_m[i] = 1'b1;
            data_m[i]  = '0;
        end
    endtask

    task automatic add_row(input string name, input int reps, input int n_disp,
                           input logic [1:0] w_reg, input int off0, input rob_ctrl_e ctrl0,
                           input int off1, input rob_ctrl_e ctrl1, input int exp_wr,
                           input bit drain);
        row_t r;
        r.name   = name;
        r.reps   = reps;
        r.n_disp = n_disp;
        r.w_reg  = w_reg;
        r.off0   = off0;
        r.ctrl0  = ctrl0;
        r.off1   = off1;
        r.ctrl1  = ctrl1;
        r.exp_wr = exp_wr;
        r.drain  = drain;
        rows.push_back(r);
    endtask

    // exp_wr counts arf writes seen in the cycle the row is driven, -1 is free
    task automatic build_table();
        add_row("idle after reset", 4, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("dispatch pair a", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("younger completes", 1, 0, 2'b00, 1, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("younger only done", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("older completes", 1, 0, 2'b00, 0, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("pair retires", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 2, 0);
        add_row("dispatch pair b", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("older only done", 1, 0, 2'b00, 0, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("single retire", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 1, 0);
        add_row("complete last", 1, 0, 2'b00, 0, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("retire last", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 1, 0);
        add_row("no-write pair", 1, 2, 2'b01, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("complete no-write", 1, 0, 2'b00, 0, ctrl_none, 1, ctrl_none, 0, 0);
        add_row("retire no-write", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 1, 0);
        add_row("ooo dispatch 1", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("ooo dispatch 2", 1, 2, 2'b11, 1, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("ooo youngest", 1, 0, 2'b00, 3, ctrl_none, 2, ctrl_none, 0, 0);
        add_row("ooo oldest", 1, 0, 2'b00, 0, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("ooo retire 1", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 2, 0);
        add_row("ooo retire 2", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 2, 0);
        add_row("exc dispatch 1", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("exc dispatch 2", 1, 2, 2'b11, 0, ctrl_exception, NO_CDB, ctrl_none, 0, 0);
        add_row("exc retires", 1, 0, 2'b00, 1, ctrl_none, 2, ctrl_none, 0, 0);
        add_row("flush discards", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("idle after flush", 3, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("slot1 exc pair", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("slot1 exc result", 1, 0, 2'b00, 0, ctrl_none, 1, ctrl_exception, 0, 0);
        add_row("slot1 exc retire", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 1, 0);
        add_row("slot1 exc flush", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("bpu pair", 1, 2, 2'b11, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
        add_row("bpu results", 1, 0, 2'b00, 0, ctrl_bpu_fail, 1, ctrl_none, 0, 0);
        add_row("bpu retire", 1, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 2, 0);
        add_row("fill stream", 40, 2, 2'b11, RND_CDB, ctrl_none, NO_CDB, ctrl_none, -1, 0);
        add_row("wrap stream", 60, 1, 2'b01, RND_CDB, ctrl_none, RND_CDB, ctrl_none, -1, 0);
        add_row("drain", 0, 0, 2'b00, RND_CDB, ctrl_none, RND_CDB, ctrl_none, -1, 1);
        add_row("idle after wrap", 4, 0, 2'b00, NO_CDB, ctrl_none, NO_CDB, ctrl_none, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one clock cycle: check, drive, update the model at the edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_cycle(input row_t r);
        int         n;
        int         off;
        int         pick;
        int         pos [2];
        int         pend [$];
        int         n_ret;
        bit         exc_ret;
        logic [1:0] exp_we;
        logic [5:0] sidx;
        ent_t       e;

        // retire prediction from the state at the last edge
        n_ret   = 0;
        exc_ret = 1'b0;
        exp_we  = 2'b00;
        if (!flush_pend) begin
            for (int k = 0; k < 2; k++) begin
                if (n_ret == k && !exc_ret && rob_q.size() > k && rob_q[k].done) begin
                    n_ret     = k + 1;
                    exc_ret   = rob_q[k].exc;
                    exp_we[k] = rob_q[k].w_reg && !rob_q[k].exc;
                end
            end
        end

        check_val({r.name, " flush_o"}, 64'(flush_pend), 64'(flush_o));
        // tail follows the oldest in-flight entry and wraps past 63
        check_val({r.name, " tail index"}, 64'(m_tail), 64'(DUT.u_cmt_if.tail_idx));
        check_val({r.name, " arf_we_o"}, 64'(exp_we), 64'(arf_we_o));
        for (int k = 0; k < 2; k++) begin
            if (exp_we[k]) begin
                check_val({r.name, " arf_addr_o"}, 64'(rob_q[k].areg), 64'(arf_addr_o[k]));
                check_val({r.name, " arf_data_o"}, 64'(rob_q[k].data), 64'(arf_data_o[k]));
            end
        end
        if (r.exp_wr >= 0) begin
            check_val({r.name, " write count"}, 64'(r.exp_wr), 64'($countones(arf_we_o)));
        end

        // dispatch, indices handed out in order behind the oldest entry
        dispatch_issue_i = 2'b00;
        cdb_w_valid_i    = 2'b00;
        n = r.n_disp;
        if (rob_q.size() + n > DEPTH) begin
            n = DEPTH - rob_q.size();
        end
        for (int k = 0; k < n; k++) begin
            dispatch_issue_i[k] = 1'b1;
            dispatch_idx_i[k]   = m_tail + 6'(rob_q.size() + k);
            dispatch_areg_i[k]  = 5'(rand_bits(5));
            dispatch_pc_i[k]    = rand_bits(32);
            dispatch_w_reg_i[k] = r.w_reg[k];
            dispatch_w_mem_i[k] = 1'(rand_bits(1));
        end

        // results for pending entries, fixed or lfsr picked
        pos[0] = -1;
        pos[1] = -1;
        for (int k = 0; k < 2; k++) begin
            off = (k == 0) ? r.off0 : r.off1;
            if (off == RND_CDB) begin
                pend.delete();
                for (int i = 0; i < rob_q.size(); i++) begin
                    if (!rob_q[i].done && i != pos[0]) begin
                        pend.push_back(i);
                    end
                end
                if (pend.size() > 0) begin
                    pick   = int'(rand_bits(6)) % pend.size();
                    pos[k] = pend[pick];
                end
            end else if (off >= 0) begin
                ensure(off < rob_q.size() && !rob_q[off].done,
                       {r.name, ": table row sends a result to an entry that is not pending"});
                pos[k] = off;
            end
            if (pos[k] >= 0) begin
                cdb_w_valid_i[k] = 1'b1;
                cdb_idx_i[k]     = rob_q[pos[k]].idx;
                cdb_w_data_i[k]  = rand_bits(32);
                cdb_ctrl_i[k]    = (k == 0) ? r.ctrl0 : r.ctrl1;
            end
        end

        // oldest and youngest in flight, plus two random indices
        for (int s = 0; s < 4; s++) begin
            src_idx_i[s] = 6'(rand_bits(6));
        end
        if (rob_q.size() > 0) begin
            src_idx_i[0] = rob_q[0].idx;
            src_idx_i[1] = rob_q[rob_q.size()-1].idx;
        end
        #1;
        for (int s = 0; s < 4; s++) begin
            sidx = src_idx_i[s];
            check_val({r.name, " src_ready_o"}, 64'(ready_m[sidx]), 64'(src_ready_o[s]));
            if (ready_m[sidx]) begin
                check_val({r.name, " src_data_o"}, 64'(data_m[sidx]), 64'(src_data_o[s]));
            end
        end

        @(posedge clk);
        if (flush_pend) begin
            clear_model();
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (pos[k] >= 0) begin
                    e              = rob_q[pos[k]];
                    e.done         = 1'b1;
                    e.exc          = (cdb_ctrl_i[k] == ctrl_exception);
                    e.data         = cdb_w_data_i[k];
                    rob_q[pos[k]]  = e;
                    ready_m[e.idx] = 1'b1;
                    data_m[e.idx]  = e.data;
                end
            end
            for (int k = 0; k < n_ret; k++) begin
                void'(rob_q.pop_front());
            end
            m_tail = m_tail + 6'(n_ret);
            for (int k = 0; k < n; k++) begin
                e.idx   = dispatch_idx_i[k];
                e.areg  = dispatch_areg_i[k];
                e.w_reg = dispatch_w_reg_i[k];
                e.done  = 1'b0;
                e.exc   = 1'b0;
                e.data  = '0;
                rob_q.push_back(e);
                ready_m[e.idx] = 1'b0;
            end
            flush_pend = exc_ret;
        end
        @(negedge clk);
    endtask

    initial begin
        clk              = 1'b0;
        rst_i            = 1'b1;
        dispatch_issue_i = '0;
        dispatch_idx_i   = '0;
        dispatch_areg_i  = '0;
        dispatch_pc_i    = '0;
        dispatch_w_reg_i = '0;
        dispatch_w_mem_i = '0;
        cdb_w_valid_i    = '0;
        cdb_idx_i        = '0;
        cdb_w_data_i     = '0;
        cdb_ctrl_i[0]    = ctrl_none;
        cdb_ctrl_i[1]    = ctrl_none;
        src_idx_i        = '0;
        lfsr_q           = 32'd78837;
        n_checks         = 0;
        build_table();
        clear_model();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        foreach (rows[i]) begin
            for (int rep = 0; rep < rows[i].reps; rep++) begin
                run_cycle(rows[i]);
            end
            if (rows[i].drain) begin
                guard = 0;
                while ((rob_q.size() != 0 || flush_o) && guard < DRAIN_LIMIT) begin
                    run_cycle(rows[i]);
                    guard++;
                end
                ensure(guard < DRAIN_LIMIT, "timeout waiting for the ROB to drain");
            end
        end

        if (n_checks > 0) begin
            $display("sim passed");
        end else begin
            $display("no checks were run");
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rob_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_asserts (
    input wire logic       clk,
    input wire logic       rst_i,
    input wire logic [1:0] commit_req_i,
    input wire logic       flush_i,
    input wire logic [1:0] arf_we_i
);

    ////////////////////////////////////////////////////////////////////////////
    // retire order and flush behaviour of the commit unit
    ////////////////////////////////////////////////////////////////////////////

    // younger slot only retires behind the older one
    a_req_order: assert property (
        @(posedge clk) disable iff (rst_i)
        commit_req_i[1] |-> commit_req_i[0]
    ) else $error("commit_req[1] high while commit_req[0] is low");

    // flush is a single-cycle pulse
    a_flush_pulse: assert property (
        @(posedge clk) disable iff (rst_i)
        flush_i |=> !flush_i
    ) else $error("flush held high for two cycles in a row");

    // no architectural write while the ROB is being emptied
    a_no_write_in_flush: assert property (
        @(posedge clk) disable iff (rst_i)
        flush_i |-> (arf_we_i == 2'b00)
    ) else $error("register file write during a flush cycle");

endmodule

`default_nettype wire

/* rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
    parameter int ROB_WIDTH = 6
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst_i,
    // dispatch pair
    input  wire logic [1:0]                               dispatch_issue_i,
    input  wire logic [1:0][ROB_WIDTH-1:0]                dispatch_idx_i,
    input  wire logic [1:0][rob_cfg_pkg::AREG_W-1:0]      dispatch_areg_i,
    input  wire logic [1:0][31:0]                         dispatch_pc_i,
    input  wire logic [1:0]                               dispatch_w_reg_i,
    input  wire logic [1:0]                               dispatch_w_mem_i,
    // CDB pair
    input  wire logic [1:0]                               cdb_w_valid_i,
    input  wire logic [1:0][ROB_WIDTH-1:0]                cdb_idx_i,
    input  wire logic [1:0][rob_cfg_pkg::DATA_W-1:0]      cdb_w_data_i,
    input  wire rob_cfg_pkg::rob_ctrl_e [1:0]             cdb_ctrl_i,
    // source operand read
    input  wire logic [3:0][ROB_WIDTH-1:0]                src_idx_i,
    output logic      [3:0][rob_cfg_pkg::DATA_W-1:0]      src_data_o,
    output logic      [3:0]                               src_ready_o,
    // architectural register file writes
    output logic      [1:0]                               arf_we_o,
    output logic      [1:0][rob_cfg_pkg::AREG_W-1:0]      arf_addr_o,
    output logic      [1:0][rob_cfg_pkg::DATA_W-1:0]      arf_data_o,
    output logic                                          flush_o
);

    import rob_bus_pkg::*;

    dispatch_rec_t [1:0] disp;
    cdb_rec_t      [1:0] cdb;

    // pack the plain ports into stage records
    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign disp[i].issue  = dispatch_issue_i[i];
        assign disp[i].areg   = dispatch_areg_i[i];
        assign disp[i].pc     = dispatch_pc_i[i];
        assign disp[i].w_reg  = dispatch_w_reg_i[i];
        assign disp[i].w_mem  = dispatch_w_mem_i[i];
        assign cdb[i].w_valid = cdb_w_valid_i[i];
        assign cdb[i].w_data  = cdb_w_data_i[i];
        assign cdb[i].ctrl    = cdb_ctrl_i[i];
    end

    rob_commit_if #(
        .ROB_WIDTH (ROB_WIDTH)
    ) u_cmt_if ();

    rob #(
        .ROB_WIDTH (ROB_WIDTH)
    ) u_rob (
        .clk         (clk),
        .rst_i       (rst_i),
        .disp_i      (disp),
        .disp_idx_i  (dispatch_idx_i),
        .cdb_i       (cdb),
        .cdb_idx_i   (cdb_idx_i),
        .src_idx_i   (src_idx_i),
        .src_data_o  (src_data_o),
        .src_ready_o (src_ready_o),
        .cmt         (u_cmt_if.rob_side)
    );

    commit_unit u_commit (
        .clk        (clk),
        .rst_i      (rst_i),
        .cmt        (u_cmt_if.commit_side),
        .arf_we_o   (arf_we_o),
        .arf_addr_o (arf_addr_o),
        .arf_data_o (arf_data_o),
        .flush_o    (flush_o)
    );

endmodule

`default_nettype wire

/* commit_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input  wire logic                                 clk,
    input  wire logic                                 rst_i,
    rob_commit_if.commit_side                         cmt,
    output logic      [1:0]                           arf_we_o,
    output logic      [1:0][rob_cfg_pkg::AREG_W-1:0]  arf_addr_o,
    output logic      [1:0][rob_cfg_pkg::DATA_W-1:0]  arf_data_o,
    output logic                                      flush_o
);

    import rob_cfg_pkg::*;

    logic [1:0] is_exc;
    logic [1:0] req;
    logic       flush_d;
    logic       flush_q;

    ////////////////////////////////////////////////////////////////////////////
    // in-order retire decision
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            is_exc[k] = (cmt.cand[k].ctrl == ctrl_exception);
        end
        // nothing retires while the flush is in progress
        req[0] = cmt.cand[0].c_valid && !flush_q;
        // younger slot only behind a clean older retire
        req[1] = req[0] && !is_exc[0] && cmt.cand[1].c_valid;
    end

    assign cmt.commit_req = req;

    // architectural writes, exceptions suppress the write
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            arf_we_o[k]   = req[k] && cmt.cand[k].w_reg && !is_exc[k];
            arf_addr_o[k] = cmt.cand[k].w_areg;
            arf_data_o[k] = cmt.cand[k].w_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // exception flush, one cycle after the faulting retire
    ////////////////////////////////////////////////////////////////////////////

    assign flush_d = (req[0] && is_exc[0]) || (req[1] && is_exc[1]);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush_d;
        end
    end

    assign cmt.flush = flush_q;
    assign flush_o   = flush_q;

endmodule

`default_nettype wire

/* rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int ROB_WIDTH = 6
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst_i,
    input  wire rob_bus_pkg::dispatch_rec_t [1:0]          disp_i,
    input  wire logic [1:0][ROB_WIDTH-1:0]                 disp_idx_i,
    input  wire rob_bus_pkg::cdb_rec_t [1:0]               cdb_i,
    input  wire logic [1:0][ROB_WIDTH-1:0]                 cdb_idx_i,
    input  wire logic [3:0][ROB_WIDTH-1:0]                 src_idx_i,
    output logic      [3:0][rob_cfg_pkg::DATA_W-1:0]       src_data_o,
    output logic      [3:0]                                src_ready_o,
    rob_commit_if.rob_side                                 cmt
);

    import rob_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // tail pointer and occupancy
    ////////////////////////////////////////////////////////////////////////////

    logic [ROB_WIDTH-1:0] tail_q;
    logic [ROB_WIDTH-1:0] tail1;
    logic [ROB_WIDTH:0]   cnt_q;
    logic [1:0]           disp_we;
    logic [1:0]           cdb_we;
    logic [1:0]           n_disp;
    logic [1:0]           n_ret;

    assign disp_we = {disp_i[1].issue, disp_i[0].issue};
    assign cdb_we  = {cdb_i[1].w_valid, cdb_i[0].w_valid};
    assign n_disp  = {1'b0, disp_we[0]} + {1'b0, disp_we[1]};
    assign n_ret   = {1'b0, cmt.commit_req[0]} + {1'b0, cmt.commit_req[1]};
    assign tail1   = tail_q + {{(ROB_WIDTH-1){1'b0}}, 1'b1};

    always_ff @(posedge clk) begin
        if (rst_i || cmt.flush) begin
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            tail_q <= tail_q + {{(ROB_WIDTH-2){1'b0}}, n_ret};
            cnt_q  <= cnt_q + {{(ROB_WIDTH-1){1'b0}}, n_disp}
                            - {{(ROB_WIDTH-1){1'b0}}, n_ret};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry tables
    ////////////////////////////////////////////////////////////////////////////

    rob_inst_entry_t [1:0] disp_inst;
    rob_inst_entry_t [1:0] cmt_inst;
    rob_data_entry_t [1:0] cdb_data;
    // 0..3 sources, 4..5 commit slots
    rob_data_entry_t [5:0] data_rd;
    logic            [5:0] complete;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            disp_inst[i].areg  = disp_i[i].areg;
            disp_inst[i].pc    = disp_i[i].pc;
            disp_inst[i].w_reg = disp_i[i].w_reg;
            disp_inst[i].w_mem = disp_i[i].w_mem;
            cdb_data[i].data   = cdb_i[i].w_data;
            cdb_data[i].ctrl   = cdb_i[i].ctrl;
        end
    end

    rob_entry_table #(
        .ROB_WIDTH (ROB_WIDTH),
        .DATA_W_P  ($bits(rob_inst_entry_t)),
        .R_PORTS   (2),
        .W_PORTS   (2)
    ) u_inst_table (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr_i ({tail1, tail_q}),
        .rdata_o (cmt_inst),
        .waddr_i (disp_idx_i),
        .we_i    (disp_we),
        .wdata_i (disp_inst),
        .clr_i   (cmt.flush)
    );

    rob_entry_table #(
        .ROB_WIDTH (ROB_WIDTH),
        .DATA_W_P  ($bits(rob_data_entry_t)),
        .R_PORTS   (6),
        .W_PORTS   (2)
    ) u_data_table (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr_i ({tail1, tail_q, src_idx_i}),
        .rdata_o (data_rd),
        .waddr_i (cdb_idx_i),
        .we_i    (cdb_we),
        .wdata_i (cdb_data),
        .clr_i   (cmt.flush)
    );

    rob_complete_table #(
        .ROB_WIDTH (ROB_WIDTH)
    ) u_complete (
        .clk        (clk),
        .rst_i      (rst_i),
        .clr_i      (cmt.flush),
        .disp_we_i  (disp_we),
        .disp_idx_i (disp_idx_i),
        .cdb_we_i   (cdb_we),
        .cdb_idx_i  (cdb_idx_i),
        .rd_idx_i   ({tail1, tail_q, src_idx_i}),
        .complete_o (complete)
    );

    // source read-out, no CDB bypass
    always_comb begin
        for (int s = 0; s < 4; s++) begin
            src_data_o[s]  = data_rd[s].data;
            src_ready_o[s] = complete[s];
        end
    end

    // commit candidates at tail and tail+1
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            cmt.cand[k].c_valid = (cnt_q > k) && complete[4+k];
            cmt.cand[k].w_areg  = cmt_inst[k].areg;
            cmt.cand[k].w_data  = data_rd[4+k].data;
            cmt.cand[k].w_reg   = cmt_inst[k].w_reg;
            cmt.cand[k].w_mem   = cmt_inst[k].w_mem;
            cmt.cand[k].ctrl    = data_rd[4+k].ctrl;
        end
    end

    assign cmt.tail_idx = tail_q;

endmodule

`default_nettype wire

/* rob_commit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rob_commit_if #(
    parameter int ROB_WIDTH = 6
);
    import rob_bus_pkg::*;

    // slot 0 is the oldest entry
    commit_rec_t [1:0]    cand;
    // index of slot 0, lets retire order be traced
    logic [ROB_WIDTH-1:0] tail_idx;
    logic [1:0]           commit_req;
    logic                 flush;

    modport rob_side (
        output cand,
        output tail_idx,
        input  commit_req,
        input  flush
    );

    modport commit_side (
        input  cand,
        input  tail_idx,
        output commit_req,
        output flush
    );

endinterface

`default_nettype wire

/* rob_complete_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_complete_table #(
    parameter int ROB_WIDTH = 6
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      clr_i,
    input  wire logic [1:0]                disp_we_i,
    input  wire logic [1:0][ROB_WIDTH-1:0] disp_idx_i,
    input  wire logic [1:0]                cdb_we_i,
    input  wire logic [1:0][ROB_WIDTH-1:0] cdb_idx_i,
    input  wire logic [5:0][ROB_WIDTH-1:0] rd_idx_i,
    output logic      [5:0]                complete_o
);

    ////////////////////////////////////////////////////////////////////////////
    // flip tables: dispatch toggles one, CDB toggles the other
    // read ports 0..5 serve the callers, 6..7 read back the writer's own bit
    ////////////////////////////////////////////////////////////////////////////

    logic [7:0] disp_rd;
    logic [7:0] cdb_rd;

    rob_entry_table #(
        .ROB_WIDTH (ROB_WIDTH),
        .DATA_W_P  (1),
        .R_PORTS   (8),
        .W_PORTS   (2)
    ) u_disp_flip (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr_i ({disp_idx_i, rd_idx_i}),
        .rdata_o (disp_rd),
        .waddr_i (disp_idx_i),
        .we_i    (disp_we_i),
        .wdata_i (~disp_rd[7:6]),
        .clr_i   (clr_i)
    );

    rob_entry_table #(
        .ROB_WIDTH (ROB_WIDTH),
        .DATA_W_P  (1),
        .R_PORTS   (8),
        .W_PORTS   (2)
    ) u_cdb_flip (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr_i ({cdb_idx_i, rd_idx_i}),
        .rdata_o (cdb_rd),
        .waddr_i (cdb_idx_i),
        .we_i    (cdb_we_i),
        .wdata_i (~cdb_rd[7:6]),
        .clr_i   (clr_i)
    );

    // equal bits mean the result caught up with the dispatch
    assign complete_o = ~(disp_rd[5:0] ^ cdb_rd[5:0]);

endmodule

`default_nettype wire

/* rob_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_entry_table #(
    parameter int ROB_WIDTH = 6,
    parameter int DATA_W_P  = 32,
    parameter int R_PORTS   = 2,
    parameter int W_PORTS   = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_i,
    input  wire logic [R_PORTS-1:0][ROB_WIDTH-1:0]      raddr_i,
    output logic      [R_PORTS-1:0][DATA_W_P-1:0]       rdata_o,
    input  wire logic [W_PORTS-1:0][ROB_WIDTH-1:0]      waddr_i,
    input  wire logic [W_PORTS-1:0]                     we_i,
    input  wire logic [W_PORTS-1:0][DATA_W_P-1:0]       wdata_i,
    input  wire logic                                   clr_i
);

    localparam int DEPTH = 1 << ROB_WIDTH;

    logic [DATA_W_P-1:0] mem_q [DEPTH];

    // reads see the table as of the last edge
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || clr_i) begin
            for (int e = 0; e < DEPTH; e++) begin
                mem_q[e] <= '0;
            end
        end else begin
            // higher port wins on a shared address
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rob_bus_pkg.sv */
`default_nettype none

package rob_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // records between pipeline stages, indices travel beside them
    ////////////////////////////////////////////////////////////////////////////

    // one instruction from the dispatcher
    typedef struct packed {
        logic                           issue;
        logic [rob_cfg_pkg::AREG_W-1:0] areg;
        logic [31:0]                    pc;
        logic                           w_reg;
        logic                           w_mem;
    } dispatch_rec_t;

    // one result from the CDB
    typedef struct packed {
        logic                           w_valid;
        logic [rob_cfg_pkg::DATA_W-1:0] w_data;
        rob_cfg_pkg::rob_ctrl_e         ctrl;
    } cdb_rec_t;

    // one retire candidate, built from the oldest entries
    typedef struct packed {
        logic                           c_valid;
        logic [rob_cfg_pkg::AREG_W-1:0] w_areg;
        logic [rob_cfg_pkg::DATA_W-1:0] w_data;
        logic                           w_reg;
        logic                           w_mem;
        rob_cfg_pkg::rob_ctrl_e         ctrl;
    } commit_rec_t;

endpackage

`default_nettype wire

/* rob_cfg_pkg.sv */
`default_nettype none

package rob_cfg_pkg;

    // result word and architectural register number
    localparam int DATA_W = 32;
    localparam int AREG_W = 5;

    // control code that a result carries in from the CDB
    typedef enum logic [1:0] {
        ctrl_none      = 2'd0,
        ctrl_exception = 2'd1,
        ctrl_bpu_fail  = 2'd2
    } rob_ctrl_e;

    // instruction table entry, written at dispatch
    typedef struct packed {
        logic [AREG_W-1:0] areg;
        logic [31:0]       pc;
        logic              w_reg;
        logic              w_mem;
    } rob_inst_entry_t;

    // data table entry, written by the CDB
    typedef struct packed {
        logic [DATA_W-1:0] data;
        rob_ctrl_e         ctrl;
    } rob_data_entry_t;

endpackage

`default_nettype wire
